//--- hdl/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// ******************************
// Datapath widths
// ******************************

// Data and address width
`define XLEN 32

// Architectural register file
`define ARCH_REGS 32
`define AREG_W 5

// Physical register file, shared by all renamed values
`define PHYS_REGS 64
`define PREG_W 6

// ******************************
// Buffer depths
// ******************************

// Fetch packets waiting for decode
`define IQ_DEPTH 8

`endif

//--- hdl/decode_pkg.sv
`include "decode_defines.svh"

package decode_pkg;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f
    } opcode_e;

    // Operation handed on to execute
    typedef enum logic [3:0] {
        ALU_ADDU    = 4'd0,
        ALU_SUBU    = 4'd1,
        ALU_AND     = 4'd2,
        ALU_OR      = 4'd3,
        ALU_SLT     = 4'd4,
        ALU_SLL     = 4'd5,
        ALU_LUI     = 4'd6,
        ALU_ILLEGAL = 4'd7
    } alu_op_e;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } fetch_pkt_t;

    // ******************************
    // Stage payloads
    // ******************************

    typedef struct packed {
        alu_op_e            alu_op;
        logic [`AREG_W-1:0] src_a;
        logic [`AREG_W-1:0] src_b;
        logic [`AREG_W-1:0] dest;
        logic               dest_we;
        logic               use_imm;
        logic [`XLEN-1:0]   imm;
        logic [4:0]         shamt;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   instr;
    } dec_op_t;

    // Same op with every register index translated to physical
    typedef struct packed {
        alu_op_e            alu_op;
        logic [`PREG_W-1:0] src_a_preg;
        logic [`PREG_W-1:0] src_b_preg;
        logic [`PREG_W-1:0] dest_preg;
        logic [`PREG_W-1:0] old_preg;
        logic               dest_we;
        logic               use_imm;
        logic [`XLEN-1:0]   imm;
        logic [4:0]         shamt;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   instr;
    } renamed_op_t;

    typedef struct packed {
        renamed_op_t      op;
        logic [`XLEN-1:0] opa;
        logic [`XLEN-1:0] opb;
        logic             opa_ready;
        logic             opb_ready;
    } dispatch_op_t;

    // Result broadcast from execute
    typedef struct packed {
        logic               valid;
        logic [`PREG_W-1:0] preg;
        logic [`XLEN-1:0]   value;
    } wb_t;

    // Physical register handle, used for release and allocation
    typedef struct packed {
        logic               valid;
        logic [`PREG_W-1:0] preg;
    } release_t;

endpackage

//--- hdl/instr_queue.sv
`timescale 1ns/10ps
`include "decode_defines.svh"

module instr_queue import decode_pkg::*; (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       flush,
    input  fetch_pkt_t in_pkt,
    input  logic       in_valid,
    output logic       in_ready,
    output fetch_pkt_t head,
    output logic       head_valid,
    input  logic       pop
);

    localparam int PTR_W = $clog2(`IQ_DEPTH);
    localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

    fetch_pkt_t       buffer [`IQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             take;

    assign in_ready   = (count != CNT_W'(`IQ_DEPTH));
    assign head_valid = (count != '0);
    assign head       = buffer[rd_ptr];

    // Pop is ignored while empty
    assign push = in_valid && in_ready;
    assign take = pop && head_valid;

    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (take)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + CNT_W'(push) - CNT_W'(take);
        end
    end

    always_ff @(posedge CLK) begin
        if (push)
            buffer[wr_ptr] <= in_pkt;
    end

endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/10ps
`include "decode_defines.svh"

module instr_decoder import decode_pkg::*; (
    input  fetch_pkt_t pkt,
    output dec_op_t    op
);

    opcode_e            opcode;
    logic [`AREG_W-1:0] rs;
    logic [`AREG_W-1:0] rt;
    logic [`AREG_W-1:0] rd;
    logic [15:0]        imm16;
    logic [5:0]         funct;

    // Instruction fields
    assign opcode = opcode_e'(pkt.instr[31:26]);
    assign rs     = pkt.instr[25:21];
    assign rt     = pkt.instr[20:16];
    assign rd     = pkt.instr[15:11];
    assign imm16  = pkt.instr[15:0];
    assign funct  = pkt.instr[5:0];

    always_comb begin
        // Default is an illegal op with no sources and no dest
        op        = '0;
        op.alu_op = ALU_ILLEGAL;
        op.pc     = pkt.pc;
        op.instr  = pkt.instr;

        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    6'h21:   op.alu_op = ALU_ADDU;
                    6'h23:   op.alu_op = ALU_SUBU;
                    6'h24:   op.alu_op = ALU_AND;
                    6'h25:   op.alu_op = ALU_OR;
                    6'h2a:   op.alu_op = ALU_SLT;
                    6'h00:   op.alu_op = ALU_SLL;
                    default: op.alu_op = ALU_ILLEGAL;
                endcase
                if (op.alu_op != ALU_ILLEGAL) begin
                    op.src_a   = rs;
                    op.src_b   = rt;
                    op.dest    = rd;
                    op.dest_we = 1'b1;
                    op.shamt   = pkt.instr[10:6];
                end
            end
            OP_ADDIU: begin
                op.alu_op  = ALU_ADDU;
                op.src_a   = rs;
                op.dest    = rt;
                op.dest_we = 1'b1;
                op.use_imm = 1'b1;
                op.imm     = {{16{imm16[15]}}, imm16};
            end
            OP_ANDI, OP_ORI: begin
                op.alu_op  = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
                op.src_a   = rs;
                op.dest    = rt;
                op.dest_we = 1'b1;
                op.use_imm = 1'b1;
                op.imm     = {16'h0000, imm16};
            end
            OP_LUI: begin
                // No register source
                op.alu_op  = ALU_LUI;
                op.dest    = rt;
                op.dest_we = 1'b1;
                op.use_imm = 1'b1;
                op.imm     = {imm16, 16'h0000};
            end
            default: op.alu_op = ALU_ILLEGAL;
        endcase
    end

endmodule

//--- hdl/rename_map.sv
`timescale 1ns/10ps
`include "decode_defines.svh"

module rename_map import decode_pkg::*; (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        flush,
    input  dec_op_t     dec_op,
    input  logic        dec_valid,
    output logic        dec_ready,
    output renamed_op_t ren_op,
    output logic        ren_valid,
    input  logic        ren_ready,
    input  release_t    rel,
    output release_t    alloc
);

    localparam int FREE_N = `PHYS_REGS - `ARCH_REGS;
    localparam int FP_W   = $clog2(FREE_N);
    localparam int FC_W   = $clog2(FREE_N + 1);

    logic [`PREG_W-1:0] map_table [`ARCH_REGS];
    logic [`PREG_W-1:0] free_list [FREE_N];
    logic [FP_W-1:0]    free_head;
    logic [FP_W-1:0]    free_tail;
    logic [FC_W-1:0]    free_cnt;
    logic               need_alloc;
    logic               fire;
    logic               take_free;
    logic               rel_push;
    logic [`PREG_W-1:0] new_preg;
    renamed_op_t        ren_next;

    // Writes to r0 are dropped, no register needed
    assign need_alloc = dec_op.dest_we && (dec_op.dest != '0);
    assign dec_ready  = !flush && (!ren_valid || ren_ready) &&
                        (!need_alloc || (free_cnt != '0));
    assign fire       = dec_valid && dec_ready;
    assign take_free  = fire && need_alloc;
    assign rel_push   = rel.valid && (rel.preg != '0);
    assign new_preg   = free_list[free_head];

    // Register file clears the ready bit of the new register
    assign alloc.valid = take_free;
    assign alloc.preg  = new_preg;

    // Sources see the map before this op's own update
    always_comb begin
        ren_next.alu_op     = dec_op.alu_op;
        ren_next.src_a_preg = map_table[dec_op.src_a];
        ren_next.src_b_preg = map_table[dec_op.src_b];
        ren_next.dest_preg  = need_alloc ? new_preg : '0;
        ren_next.old_preg   = need_alloc ? map_table[dec_op.dest] : '0;
        ren_next.dest_we    = need_alloc;
        ren_next.use_imm    = dec_op.use_imm;
        ren_next.imm        = dec_op.imm;
        ren_next.shamt      = dec_op.shamt;
        ren_next.pc         = dec_op.pc;
        ren_next.instr      = dec_op.instr;
    end

    // ******************************
    // Map table and free list
    // ******************************

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < `ARCH_REGS; i++)
                map_table[i] <= `PREG_W'(i);
            for (int i = 0; i < FREE_N; i++)
                free_list[i] <= `PREG_W'(`ARCH_REGS + i);
            free_head <= '0;
            free_tail <= '0;
            free_cnt  <= FC_W'(FREE_N);
        end else begin
            if (take_free) begin
                map_table[dec_op.dest] <= new_preg;
                free_head              <= free_head + 1'b1;
            end
            if (rel_push) begin
                free_list[free_tail] <= rel.preg;
                free_tail            <= free_tail + 1'b1;
            end
            free_cnt <= free_cnt + FC_W'(rel_push) - FC_W'(take_free);
        end
    end

    // Output register
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET)
            ren_valid <= 1'b0;
        else if (flush)
            ren_valid <= 1'b0;
        else if (!ren_valid || ren_ready)
            ren_valid <= fire;
    end

    always_ff @(posedge CLK) begin
        if (fire)
            ren_op <= ren_next;
    end

endmodule

//--- hdl/phys_regfile.sv
`timescale 1ns/10ps
`include "decode_defines.svh"

module phys_regfile import decode_pkg::*; (
    input  logic               CLK,
    input  logic               RESET,
    input  wb_t                wb,
    input  logic               alloc_valid,
    input  logic [`PREG_W-1:0] alloc_preg,
    input  logic [`PREG_W-1:0] rd_a,
    input  logic [`PREG_W-1:0] rd_b,
    output logic [`XLEN-1:0]   val_a,
    output logic [`XLEN-1:0]   val_b,
    output logic               rdy_a,
    output logic               rdy_b
);

    logic [`XLEN-1:0]     values [`PHYS_REGS];
    logic [`PHYS_REGS-1:0] ready;
    logic                  wb_write;

    assign wb_write = wb.valid && (wb.preg != '0);

    // Ready bit above value, same-cycle write-back bypassed
    function automatic logic [`XLEN:0] read_port(input logic [`PREG_W-1:0] addr);
        logic [`XLEN:0] result;
        if (addr == '0)
            result = {1'b1, `XLEN'(0)};
        else if (wb_write && (wb.preg == addr))
            result = {1'b1, wb.value};
        else
            result = {ready[addr], values[addr]};
        return result;
    endfunction

    always_comb begin
        {rdy_a, val_a} = read_port(rd_a);
        {rdy_b, val_b} = read_port(rd_b);
    end

    // Architectural registers start at zero and ready
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < `PHYS_REGS; i++)
                values[i] <= '0;
            ready <= {{(`PHYS_REGS - `ARCH_REGS){1'b0}}, {`ARCH_REGS{1'b1}}};
        end else begin
            if (wb_write) begin
                values[wb.preg] <= wb.value;
                ready[wb.preg]  <= 1'b1;
            end
            if (alloc_valid)
                ready[alloc_preg] <= 1'b0;
        end
    end

endmodule

//--- hdl/dispatch_stage.sv
`timescale 1ns/10ps
`include "decode_defines.svh"

module dispatch_stage import decode_pkg::*; (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               flush,
    input  renamed_op_t        ren_op,
    input  logic               ren_valid,
    output logic               ren_ready,
    output logic [`PREG_W-1:0] rd_a,
    output logic [`PREG_W-1:0] rd_b,
    input  logic [`XLEN-1:0]   val_a,
    input  logic [`XLEN-1:0]   val_b,
    input  logic               rdy_a,
    input  logic               rdy_b,
    input  wb_t                wb,
    output dispatch_op_t       out_op,
    output logic               out_valid,
    input  logic               out_ready
);

    logic load;
    logic fill_a;
    logic fill_b;

    assign rd_a      = ren_op.src_a_preg;
    assign rd_b      = ren_op.src_b_preg;
    assign ren_ready = !out_valid || out_ready;
    assign load      = ren_valid && ren_ready;

    // Late write-back for an operand still waiting
    assign fill_a = out_valid && wb.valid && !out_op.opa_ready &&
                    (wb.preg == out_op.op.src_a_preg);
    assign fill_b = out_valid && wb.valid && !out_op.opb_ready &&
                    (wb.preg == out_op.op.src_b_preg);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET)
            out_valid <= 1'b0;
        else if (flush)
            out_valid <= 1'b0;
        else if (ren_ready)
            out_valid <= ren_valid;
    end

    always_ff @(posedge CLK) begin
        if (load) begin
            out_op.op        <= ren_op;
            out_op.opa       <= val_a;
            out_op.opb       <= val_b;
            out_op.opa_ready <= rdy_a;
            out_op.opb_ready <= rdy_b;
        end else begin
            if (fill_a) begin
                out_op.opa       <= wb.value;
                out_op.opa_ready <= 1'b1;
            end
            if (fill_b) begin
                out_op.opb       <= wb.value;
                out_op.opb_ready <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/decode_rename_top.sv
`timescale 1ns/10ps
`include "decode_defines.svh"

module decode_rename_top import decode_pkg::*; (
    input  logic         CLK,
    input  logic         RESET,
    input  logic         flush,
    input  fetch_pkt_t   in_pkt,
    input  logic         in_valid,
    output logic         in_ready,
    input  wb_t          wb,
    input  release_t     rel,
    output dispatch_op_t out_op,
    output logic         out_valid,
    input  logic         out_ready
);

    fetch_pkt_t         head;
    logic               head_valid;
    dec_op_t            dec_op;
    logic               dec_ready;
    renamed_op_t        ren_op;
    logic               ren_valid;
    logic               ren_ready;
    release_t           alloc;
    logic [`PREG_W-1:0] rd_a;
    logic [`PREG_W-1:0] rd_b;
    logic [`XLEN-1:0]   val_a;
    logic [`XLEN-1:0]   val_b;
    logic               rdy_a;
    logic               rdy_b;

    // Queue pops itself only when non-empty
    instr_queue iq0 (
        .CLK(CLK), .RESET(RESET), .flush(flush),
        .in_pkt(in_pkt), .in_valid(in_valid), .in_ready(in_ready),
        .head(head), .head_valid(head_valid), .pop(dec_ready)
    );

    instr_decoder dec0 (
        .pkt(head), .op(dec_op)
    );

    rename_map ren0 (
        .CLK(CLK), .RESET(RESET), .flush(flush),
        .dec_op(dec_op), .dec_valid(head_valid), .dec_ready(dec_ready),
        .ren_op(ren_op), .ren_valid(ren_valid), .ren_ready(ren_ready),
        .rel(rel), .alloc(alloc)
    );

    phys_regfile prf0 (
        .CLK(CLK), .RESET(RESET), .wb(wb),
        .alloc_valid(alloc.valid), .alloc_preg(alloc.preg),
        .rd_a(rd_a), .rd_b(rd_b),
        .val_a(val_a), .val_b(val_b), .rdy_a(rdy_a), .rdy_b(rdy_b)
    );

    dispatch_stage dsp0 (
        .CLK(CLK), .RESET(RESET), .flush(flush),
        .ren_op(ren_op), .ren_valid(ren_valid), .ren_ready(ren_ready),
        .rd_a(rd_a), .rd_b(rd_b),
        .val_a(val_a), .val_b(val_b), .rdy_a(rdy_a), .rdy_b(rdy_b),
        .wb(wb),
        .out_op(out_op), .out_valid(out_valid), .out_ready(out_ready)
    );

endmodule

//--- bench/decode_rename_properties.sv
`timescale 1ns/10ps
`include "decode_defines.svh"

module decode_rename_properties import decode_pkg::*; (
    input logic         CLK,
    input logic         RESET,
    input logic         in_ready,
    input logic         out_valid,
    input logic         out_ready,
    input dispatch_op_t out_op,
    input logic         ren_valid,
    input renamed_op_t  ren_op
);

    // Empty pipeline while reset is held
    reset_state: assert property (@(posedge CLK) !RESET |-> (!out_valid && in_ready))
        else $error("pipeline not empty during reset");

    // Operand fields may still fill from a late write-back
    hold_stable: assert property (@(posedge CLK) disable iff (!RESET)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_op.op)))
        else $error("dispatch output changed while stalled");

    new_differs_old: assert property (@(posedge CLK) disable iff (!RESET)
        (ren_valid && ren_op.dest_we) |-> (ren_op.dest_preg != ren_op.old_preg))
        else $error("new register equals the old mapping");

endmodule

bind decode_rename_top decode_rename_properties props0 (
    .CLK(CLK), .RESET(RESET), .in_ready(in_ready),
    .out_valid(out_valid), .out_ready(out_ready), .out_op(out_op),
    .ren_valid(ren_valid), .ren_op(ren_op)
);

//--- bench/tb_decode_rename.sv
`timescale 1ns/10ps
`include "decode_defines.svh"

module tb_decode_rename import decode_pkg::*; ();

    localparam int N_RANDOM  = 200;
    localparam int N_HOLD    = 48;
    localparam int MAX_CYCLE = 4000;

    logic         CLK;
    logic         RESET;
    logic         flush;
    fetch_pkt_t   in_pkt;
    logic         in_valid;
    logic         in_ready;
    wb_t          wb;
    release_t     rel;
    dispatch_op_t out_op;
    logic         out_valid;
    logic         out_ready;

    logic [31:0]        lcg_state;
    logic [31:0]        next_pc;
    int                 cycle;
    int                 dispatched;
    int                 stall_run;
    int                 last_due;
    logic               hold_rel;
    logic               hold_done;
    logic               saw_full;
    logic [31:0]        ref_regs [`ARCH_REGS];
    logic [`PREG_W-1:0] ref_map [`ARCH_REGS];
    logic               in_use [`PHYS_REGS];
    fetch_pkt_t         sent_q [$];
    logic [`PREG_W-1:0] preg_q [$];
    logic [`PREG_W-1:0] old_q [$];
    logic [31:0]        val_q [$];
    int                 due_q [$];
    logic [`PREG_W-1:0] held_q [$];

    decode_rename_top dut0 (
        .CLK(CLK), .RESET(RESET), .flush(flush),
        .in_pkt(in_pkt), .in_valid(in_valid), .in_ready(in_ready),
        .wb(wb), .rel(rel),
        .out_op(out_op), .out_valid(out_valid), .out_ready(out_ready)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {lcg_state[31:16], lcg_state[15:0] ^ lcg_state[31:16]};
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            report_error($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    // Decode rules from the MIPS encoding of the kept subset
    task automatic expect_decode(input logic [31:0] instr, output alu_op_e alu,
                                 output logic we, output logic use_imm,
                                 output logic [31:0] imm, output logic [4:0] shamt,
                                 output logic [4:0] sa, output logic [4:0] sb,
                                 output logic [4:0] dst);
        alu = ALU_ILLEGAL;
        we = 1'b0;
        use_imm = 1'b0;
        imm = 32'h0;
        shamt = 5'h0;
        sa = 5'h0;
        sb = 5'h0;
        dst = 5'h0;
        case (instr[31:26])
            6'h00: begin
                case (instr[5:0])
                    6'h21: alu = ALU_ADDU;
                    6'h23: alu = ALU_SUBU;
                    6'h24: alu = ALU_AND;
                    6'h25: alu = ALU_OR;
                    6'h2a: alu = ALU_SLT;
                    6'h00: alu = ALU_SLL;
                    default: alu = ALU_ILLEGAL;
                endcase
                if (alu != ALU_ILLEGAL) begin
                    sa = instr[25:21];
                    sb = instr[20:16];
                    dst = instr[15:11];
                    shamt = instr[10:6];
                end
            end
            6'h09, 6'h0c, 6'h0d, 6'h0f: begin
                use_imm = 1'b1;
                dst = instr[20:16];
                sa = (instr[31:26] == 6'h0f) ? 5'h0 : instr[25:21];
                if (instr[31:26] == 6'h09) begin
                    alu = ALU_ADDU;
                    imm = {{16{instr[15]}}, instr[15:0]};
                end else if (instr[31:26] == 6'h0f) begin
                    alu = ALU_LUI;
                    imm = {instr[15:0], 16'h0};
                end else begin
                    alu = (instr[31:26] == 6'h0c) ? ALU_AND : ALU_OR;
                    imm = {16'h0, instr[15:0]};
                end
            end
            default: alu = ALU_ILLEGAL;
        endcase
        we = (alu != ALU_ILLEGAL) && (dst != 5'h0);
    endtask

    function automatic logic [31:0] gen_instr();
        logic [31:0] r;
        logic [31:0] f;
        logic [5:0]  funct;
        r = next_rand();
        f = next_rand();
        case (r % 12)
            0: funct = 6'h21;
            1: funct = 6'h23;
            2: funct = 6'h24;
            3: funct = 6'h25;
            4: funct = 6'h2a;
            5: funct = 6'h00;
            default: funct = 6'h3f;
        endcase
        // Low register numbers keep dependency chains short
        case (r % 12)
            6: return {6'h09, 2'b0, f[2:0], 2'b0, f[5:3], f[31:16]};
            7: return {6'h0c, 2'b0, f[2:0], 2'b0, f[5:3], f[31:16]};
            8: return {6'h0d, 2'b0, f[2:0], 2'b0, f[5:3], f[31:16]};
            9: return {6'h0f, 5'h0, 2'b0, f[5:3], f[31:16]};
            11: return {6'h3f, f[25:0]};
            default: return {6'h00, 2'b0, f[2:0], 2'b0, f[5:3], 2'b0, f[8:6],
                             f[13:9], funct};
        endcase
    endfunction

    task automatic send_pkt(input logic [31:0] instr);
        in_pkt.pc = next_pc;
        in_pkt.instr = instr;
        in_valid = 1'b1;
        @(posedge CLK);
        while (!in_ready)
            @(posedge CLK);
        #1;
        in_valid = 1'b0;
        next_pc = next_pc + 32'd4;
    endtask

    // ******************************
    // Monitor and reference model
    // ******************************

    always @(posedge CLK) begin
        alu_op_e     alu;
        logic        we;
        logic        use_imm;
        logic [31:0] imm;
        logic [4:0]  shamt;
        logic [4:0]  sa;
        logic [4:0]  sb;
        logic [4:0]  dst;
        logic [31:0] b;
        logic [31:0] res;
        fetch_pkt_t  exp_pkt;
        int          due;
        cycle = cycle + 1;
        if (cycle >= MAX_CYCLE)
            report_error("Timeout, the run did not finish in time");
        stall_run = (in_valid && !in_ready) ? stall_run + 1 : 0;
        if (RESET && in_valid && in_ready)
            sent_q.push_back(in_pkt);
        if (RESET && out_valid && out_ready) begin
            assert (sent_q.size() > 0) else
                report_error("An operation came out that was never sent");
            exp_pkt = sent_q.pop_front();
            check_value("out_op.pc", out_op.op.pc, exp_pkt.pc);
            check_value("out_op.instr", out_op.op.instr, exp_pkt.instr);
            expect_decode(exp_pkt.instr, alu, we, use_imm, imm, shamt, sa, sb, dst);
            check_value("out_op.alu_op", 32'(out_op.op.alu_op), 32'(alu));
            check_value("out_op.dest_we", 32'(out_op.op.dest_we), 32'(we));
            check_value("out_op.use_imm", 32'(out_op.op.use_imm), 32'(use_imm));
            check_value("out_op.imm", out_op.op.imm, imm);
            check_value("out_op.shamt", 32'(out_op.op.shamt), 32'(shamt));
            check_value("out_op.src_a_preg", 32'(out_op.op.src_a_preg), 32'(ref_map[sa]));
            check_value("out_op.src_b_preg", 32'(out_op.op.src_b_preg), 32'(ref_map[sb]));
            check_value("out_op.opa", out_op.opa, ref_regs[sa]);
            check_value("out_op.opb", out_op.opb, ref_regs[sb]);
            b = use_imm ? imm : ref_regs[sb];
            case (alu)
                ALU_ADDU: res = ref_regs[sa] + b;
                ALU_SUBU: res = ref_regs[sa] - b;
                ALU_AND:  res = ref_regs[sa] & b;
                ALU_OR:   res = ref_regs[sa] | b;
                ALU_SLT:  res = ($signed(ref_regs[sa]) < $signed(b)) ? 32'd1 : 32'd0;
                ALU_SLL:  res = b << shamt;
                ALU_LUI:  res = imm;
                default:  res = 32'h0;
            endcase
            if (we) begin
                assert (out_op.op.dest_preg != '0) else
                    report_error("Physical register 0 was allocated");
                assert (!in_use[out_op.op.dest_preg]) else
                    report_error("A register still in use was allocated again");
                check_value("out_op.old_preg", 32'(out_op.op.old_preg), 32'(ref_map[dst]));
                in_use[out_op.op.dest_preg] = 1'b1;
                ref_map[dst] = out_op.op.dest_preg;
                ref_regs[dst] = res;
                // Write-backs leave in order, one per cycle
                due = cycle + int'(next_rand() % 4);
                if (due <= last_due)
                    due = last_due + 1;
                last_due = due;
                preg_q.push_back(out_op.op.dest_preg);
                old_q.push_back(out_op.op.old_preg);
                val_q.push_back(res);
                due_q.push_back(due);
            end
            dispatched = dispatched + 1;
        end
    end

    // Execute side, results and releases
    always begin
        logic [`PREG_W-1:0] p;
        @(posedge CLK);
        #1;
        wb = '0;
        rel = '0;
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
            wb.valid = 1'b1;
            wb.preg = preg_q.pop_front();
            wb.value = val_q.pop_front();
            held_q.push_back(old_q.pop_front());
            void'(due_q.pop_front());
        end
        if (!hold_rel && held_q.size() > 0) begin
            p = held_q.pop_front();
            rel.valid = 1'b1;
            rel.preg = p;
            in_use[p] = 1'b0;
        end
        out_ready = (next_rand() % 3 != 0) &&
                    (!out_valid || (out_op.opa_ready && out_op.opb_ready));
    end

    initial begin
        int sent_total;
        lcg_state = 32'h6a60;
        RESET = 1'b1;
        flush = 1'b0;
        in_pkt = '0;
        in_valid = 1'b0;
        wb = '0;
        rel = '0;
        out_ready = 1'b0;
        next_pc = 32'h0040_0000;
        cycle = 0;
        dispatched = 0;
        stall_run = 0;
        last_due = 0;
        hold_rel = 1'b0;
        hold_done = 1'b0;
        saw_full = 1'b0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            ref_regs[i] = 32'h0;
            ref_map[i] = `PREG_W'(i);
        end
        for (int i = 0; i < `PHYS_REGS; i++)
            in_use[i] = (i < `ARCH_REGS);
        #2 RESET = 1'b0;
        repeat (8) @(posedge CLK);
        #1 RESET = 1'b1;

        for (int i = 0; i < N_RANDOM; i++)
            send_pkt(gen_instr());
        sent_total = N_RANDOM;
        wait (dispatched == sent_total && due_q.size() == 0 && held_q.size() == 0);

        // Withhold releases until the free list runs dry
        hold_rel = 1'b1;
        fork
            begin
                for (int i = 0; i < N_HOLD; i++)
                    send_pkt({6'h09, 5'(i % 8), 5'(1 + i % 31), 16'(i)});
                hold_done = 1'b1;
            end
            begin
                wait (stall_run >= 16 || hold_done);
                saw_full = (stall_run >= 16);
                hold_rel = 1'b0;
            end
        join
        sent_total = sent_total + N_HOLD;
        assert (saw_full) else
            report_error("in_ready never dropped while releases were withheld");
        wait (dispatched == sent_total && due_q.size() == 0);
        repeat (4) @(posedge CLK);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+hdl
hdl/decode_pkg.sv
hdl/instr_queue.sv
hdl/instr_decoder.sv
hdl/rename_map.sv
hdl/phys_regfile.sv
hdl/dispatch_stage.sv
hdl/decode_rename_top.sv
bench/decode_rename_properties.sv
bench/tb_decode_rename.sv

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, result taken from the simulation log
verilator --binary --timing --assert -f compile.f --top-module tb_decode_rename \
    -o sim_tb > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
grep -q "TESTS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "simulation did not finish, see sim.log"; exit 1; }
echo "simulation passed"
